// ==== source/cpu_consts.svh ====
// Word width, register file size and reset address constants for the core
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// ==================================================
// Datapath sizes
// ==================================================

// Core word width
`define CPU_DATA_W 16

// Core register file
`define CPU_REG_CNT 16
`define CPU_REG_AW 4

// ==================================================
// Address map
// ==================================================

// First fetch address
`define CPU_PC_RESET 16'h1000

// Offset added to every scaled data address
`define CPU_DMEM_BASE 16'h1000

`endif

// ==== source/cpu_pkg.sv ====
// Instruction formats, instruction union, opcode and ALU enums, control bundle
`include "cpu_consts.svh"

package cpu_pkg;

    // Major opcode in bits 15:13
    typedef enum logic [2:0] {
        ARITH   = 3'b000,
        CMP_MUL = 3'b001,
        LOAD    = 3'b010,
        STORE   = 3'b011,
        BRANCH  = 3'b100,
        JUMP    = 3'b101
    } cpu_opcode_e;

    // R format where func picks the second op of the opcode pair
    typedef struct packed {
        cpu_opcode_e            opcode;
        logic [`CPU_REG_AW-1:0] rs;
        logic [`CPU_REG_AW-1:0] rt;
        logic [`CPU_REG_AW-1:0] rd;
        logic                   func;
    } cpu_r_fmt_t;

    // I format for LW, SW and BEQ
    typedef struct packed {
        cpu_opcode_e            opcode;
        logic [`CPU_REG_AW-1:0] rs;
        logic [`CPU_REG_AW-1:0] rt;
        logic [4:0]             imm;
    } cpu_i_fmt_t;

    // J format with an absolute target
    typedef struct packed {
        cpu_opcode_e opcode;
        logic [12:0] target;
    } cpu_j_fmt_t;

    typedef union packed {
        cpu_r_fmt_t r;
        cpu_i_fmt_t i;
        cpu_j_fmt_t j;
    } cpu_instr_u;

    typedef enum logic [2:0] {
        ADD    = 3'd0,
        SUB    = 3'd1,
        SLT    = 3'd2,
        MUL    = 3'd3,
        ADDR   = 3'd4,
        PC_INC = 3'd5,
        BR_TGT = 3'd6
    } cpu_alu_op_e;

    // One-cycle enables from the FSM to the datapath
    typedef struct packed {
        logic        pc_inc_we;
        logic        jump_we;
        logic        branch_we;
        logic        ir_we;
        logic        opnd_we;
        logic        alu_we;
        cpu_alu_op_e alu_op;
        logic        rf_we_alu;
        logic        rf_we_mem;
        logic        mdr_we;
    } cpu_ctrl_t;

endpackage

// ==== source/cpu_alu.sv ====
// Combinational ALU for R-type ops, address, PC increment and branch target
`timescale 1ns/1ns
`include "cpu_consts.svh"

module cpu_alu import cpu_pkg::*; (
    input  cpu_alu_op_e                  i_op,
    input  logic signed [`CPU_DATA_W-1:0] i_a,
    input  logic signed [`CPU_DATA_W-1:0] i_b,
    input  logic [`CPU_DATA_W-1:0]        i_pc,
    input  logic [4:0]                    i_imm,
    output logic [`CPU_DATA_W-1:0]        o_result
);

    logic signed [`CPU_DATA_W-1:0] imm_ext;

    assign imm_ext = {{(`CPU_DATA_W-5){i_imm[4]}}, i_imm};

    always_comb
    begin
        case (i_op)
            ADD:     o_result = i_a + i_b;
            SUB:     o_result = i_a - i_b;
            SLT:     o_result = {{(`CPU_DATA_W-1){1'b0}}, (i_a < i_b)};
            // Low word of the signed product
            MUL:     o_result = i_a * i_b;
            ADDR:    o_result = i_a + imm_ext;
            PC_INC:  o_result = i_pc + 1'b1;
            // PC already points past the branch here
            BR_TGT:  o_result = i_pc + imm_ext;
            default: o_result = '0;
        endcase
    end

endmodule

// ==== source/cpu_regfile.sv ====
// Sixteen core registers, two combinational read ports and one write port
`timescale 1ns/1ns
`include "cpu_consts.svh"

module cpu_regfile (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`CPU_REG_AW-1:0] i_rs_idx,
    input  logic [`CPU_REG_AW-1:0] i_rt_idx,
    input  logic                   i_we,
    input  logic [`CPU_REG_AW-1:0] i_wr_idx,
    input  logic [`CPU_DATA_W-1:0] i_wr_data,
    output logic [`CPU_DATA_W-1:0] o_rs_data,
    output logic [`CPU_DATA_W-1:0] o_rt_data
);

    logic signed [`CPU_DATA_W-1:0] core_regs [`CPU_REG_CNT];

    // ==================================================
    // Write port
    // ==================================================
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int idx = 0; idx < `CPU_REG_CNT; idx++)
            begin
                core_regs[idx] <= '0;
            end
        end
        else if (i_we)
        begin
            core_regs[i_wr_idx] <= i_wr_data;
        end
    end

    // ==================================================
    // Read ports
    // ==================================================
    assign o_rs_data = core_regs[i_rs_idx];
    assign o_rt_data = core_regs[i_rt_idx];

endmodule

// ==== source/cpu_datapath.sv ====
// PC, IR, operand, ALU result and memory data registers with branch and address logic
`timescale 1ns/1ns
`include "cpu_consts.svh"

module cpu_datapath import cpu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  cpu_ctrl_t              i_ctrl,
    input  cpu_instr_u             i_imem_data,
    input  logic [`CPU_DATA_W-1:0] i_dmem_rdata,
    output cpu_instr_u             o_ir,
    output logic [`CPU_DATA_W-1:0] o_imem_addr,
    output logic [`CPU_DATA_W-1:0] o_dmem_addr,
    output logic [`CPU_DATA_W-1:0] o_dmem_wdata
);

    logic [`CPU_DATA_W-1:0]        pc;
    logic [`CPU_DATA_W-1:0]        fetch_addr;
    cpu_instr_u                    ir;
    logic signed [`CPU_DATA_W-1:0] opnd_a;
    logic signed [`CPU_DATA_W-1:0] opnd_b;
    logic [`CPU_DATA_W-1:0]        rs_data;
    logic [`CPU_DATA_W-1:0]        rt_data;
    logic [`CPU_DATA_W-1:0]        alu_result;
    logic [`CPU_DATA_W-1:0]        alu_out;
    logic [`CPU_DATA_W-1:0]        mdr;
    logic [`CPU_DATA_W-1:0]        jump_target;
    logic                          operands_equal;
    logic                          rf_we;
    logic [`CPU_REG_AW-1:0]        rf_wr_idx;
    logic [`CPU_DATA_W-1:0]        rf_wr_data;

    // ==================================================
    // Program counter
    // ==================================================
    assign jump_target    = `CPU_DATA_W'(ir.j.target);
    assign operands_equal = (opnd_a == opnd_b);

    // Fetch address holds the old PC while the fetch is outstanding
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pc         <= `CPU_PC_RESET;
            fetch_addr <= `CPU_PC_RESET;
        end
        else if (i_ctrl.pc_inc_we)
        begin
            fetch_addr <= pc;
            pc         <= alu_result;
        end
        else if (i_ctrl.jump_we)
        begin
            pc <= jump_target;
        end
        else if (i_ctrl.branch_we && operands_equal)
        begin
            pc <= alu_result;
        end
    end

    // ==================================================
    // Instruction, operand and result registers
    // ==================================================
    always_ff @(posedge clk)
    begin
        if (i_ctrl.ir_we)
            ir <= i_imem_data;
        if (i_ctrl.opnd_we)
        begin
            opnd_a <= rs_data;
            opnd_b <= rt_data;
        end
        if (i_ctrl.alu_we)
            alu_out <= alu_result;
        if (i_ctrl.mdr_we)
            mdr <= i_dmem_rdata;
    end

    cpu_alu alu_i (
        .i_op     (i_ctrl.alu_op),
        .i_a      (opnd_a),
        .i_b      (opnd_b),
        .i_pc     (pc),
        .i_imm    (ir.i.imm),
        .o_result (alu_result)
    );

    // ==================================================
    // Register file
    // ==================================================
    // LW writes rt, R format writes rd
    assign rf_we      = i_ctrl.rf_we_alu | i_ctrl.rf_we_mem;
    assign rf_wr_idx  = i_ctrl.rf_we_mem ? ir.i.rt : ir.r.rd;
    assign rf_wr_data = i_ctrl.rf_we_mem ? mdr : alu_out;

    cpu_regfile regfile_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_rs_idx  (ir.r.rs),
        .i_rt_idx  (ir.r.rt),
        .i_we      (rf_we),
        .i_wr_idx  (rf_wr_idx),
        .i_wr_data (rf_wr_data),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data)
    );

    // Word address scaled to bytes, then offset into data space
    assign o_dmem_addr  = (alu_out << 1) + `CPU_DMEM_BASE;
    assign o_dmem_wdata = opnd_b;
    assign o_imem_addr  = fetch_addr;
    assign o_ir         = ir;

endmodule

// ==== source/cpu_control.sv ====
// Main FSM sequencing fetch, decode, execute, memory access and writeback
`timescale 1ns/1ns

module cpu_control import cpu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  cpu_instr_u i_ir,
    input  logic       i_imem_valid,
    input  logic       i_dmem_valid,
    output cpu_ctrl_t  o_ctrl,
    output logic       o_imem_req,
    output logic       o_dmem_req,
    output logic       o_dmem_we
);

    typedef enum logic [2:0] {
        FETCH,
        FETCH_WAIT,
        DECODE,
        EXEC,
        MEM,
        MEM_WAIT,
        WB
    } state_t;

    state_t      state;
    state_t      next_state;
    logic        is_r;
    logic        is_load;
    logic        is_store;
    logic        is_branch;
    logic        is_jump;
    cpu_alu_op_e exec_op;

    // ==================================================
    // Instruction decode
    // ==================================================
    assign is_r      = (i_ir.r.opcode == ARITH) || (i_ir.r.opcode == CMP_MUL);
    assign is_load   = (i_ir.r.opcode == LOAD);
    assign is_store  = (i_ir.r.opcode == STORE);
    assign is_branch = (i_ir.r.opcode == BRANCH);
    assign is_jump   = (i_ir.r.opcode == JUMP);

    always_comb
    begin
        case (i_ir.r.opcode)
            ARITH:   exec_op = i_ir.r.func ? SUB : ADD;
            CMP_MUL: exec_op = i_ir.r.func ? MUL : SLT;
            BRANCH:  exec_op = BR_TGT;
            default: exec_op = ADDR;
        endcase
    end

    // ==================================================
    // Next state and datapath enables
    // ==================================================
    always_comb
    begin
        next_state    = state;
        o_ctrl        = '0;
        o_ctrl.alu_op = PC_INC;
        case (state)
            FETCH:
            begin
                o_ctrl.pc_inc_we = 1'b1;
                next_state       = FETCH_WAIT;
            end
            FETCH_WAIT:
            begin
                if (i_imem_valid)
                begin
                    o_ctrl.ir_we = 1'b1;
                    next_state   = DECODE;
                end
            end
            DECODE:
            begin
                o_ctrl.opnd_we = 1'b1;
                if (is_jump)
                begin
                    o_ctrl.jump_we = 1'b1;
                    next_state     = FETCH;
                end
                else if (is_r || is_load || is_store || is_branch)
                    next_state = EXEC;
                else
                    next_state = FETCH;  // undefined opcodes retire as no-ops
            end
            EXEC:
            begin
                o_ctrl.alu_op = exec_op;
                o_ctrl.alu_we = 1'b1;
                if (is_branch)
                begin
                    o_ctrl.branch_we = 1'b1;
                    next_state       = FETCH;
                end
                else if (is_r)
                    next_state = WB;
                else
                    next_state = MEM;
            end
            MEM:
            begin
                next_state = MEM_WAIT;
            end
            MEM_WAIT:
            begin
                if (i_dmem_valid)
                begin
                    o_ctrl.mdr_we = is_load;
                    next_state    = is_load ? WB : FETCH;
                end
            end
            WB:
            begin
                o_ctrl.rf_we_alu = is_r;
                o_ctrl.rf_we_mem = is_load;
                next_state       = FETCH;
            end
            default:
            begin
                next_state = FETCH;
            end
        endcase
    end

    // State and registered memory strobes
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state      <= FETCH;
            o_imem_req <= 1'b0;
            o_dmem_req <= 1'b0;
            o_dmem_we  <= 1'b0;
        end
        else
        begin
            state      <= next_state;
            o_imem_req <= (state == FETCH);
            o_dmem_req <= (state == MEM);
            o_dmem_we  <= (state == MEM) && is_store;
        end
    end

endmodule

// ==== source/cpu_top.sv ====
// Core top level joining the control FSM and datapath to the memory ports
`timescale 1ns/1ns
`include "cpu_consts.svh"

module cpu_top import cpu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    // Instruction port
    output logic                   o_imem_req,
    output logic [`CPU_DATA_W-1:0] o_imem_addr,
    input  logic                   i_imem_valid,
    input  cpu_instr_u             i_imem_data,
    // Data port
    output logic                   o_dmem_req,
    output logic                   o_dmem_we,
    output logic [`CPU_DATA_W-1:0] o_dmem_addr,
    output logic [`CPU_DATA_W-1:0] o_dmem_wdata,
    input  logic                   i_dmem_valid,
    input  logic [`CPU_DATA_W-1:0] i_dmem_rdata
);

    cpu_ctrl_t  ctrl;
    cpu_instr_u ir;

    // ==================================================
    // Control
    // ==================================================
    cpu_control control_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_ir         (ir),
        .i_imem_valid (i_imem_valid),
        .i_dmem_valid (i_dmem_valid),
        .o_ctrl       (ctrl),
        .o_imem_req   (o_imem_req),
        .o_dmem_req   (o_dmem_req),
        .o_dmem_we    (o_dmem_we)
    );

    // ==================================================
    // Datapath
    // ==================================================
    cpu_datapath datapath_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_ctrl       (ctrl),
        .i_imem_data  (i_imem_data),
        .i_dmem_rdata (i_dmem_rdata),
        .o_ir         (ir),
        .o_imem_addr  (o_imem_addr),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_wdata (o_dmem_wdata)
    );

endmodule

// ==== testbench/cpu_props.sv ====
// Concurrent assertions on the memory request strobes and their bind to the core top
`timescale 1ns/1ns

module cpu_props (
    input logic clk,
    input logic rst_n,
    input logic i_imem_req,
    input logic i_dmem_req,
    input logic i_dmem_we
);

    // Count of failed assertions
    int assert_fails = 0;

    // ==================================================
    // Request strobes
    // ==================================================
    one_port_a: assert property (@(posedge clk) disable iff (!rst_n)
        !(i_imem_req && i_dmem_req))
    else
    begin
        $error("instruction and data requests high together");
        assert_fails++;
    end

    imem_pulse_a: assert property (@(posedge clk) disable iff (!rst_n)
        i_imem_req |=> !i_imem_req)
    else
    begin
        $error("instruction request longer than one cycle");
        assert_fails++;
    end

    dmem_pulse_a: assert property (@(posedge clk) disable iff (!rst_n)
        i_dmem_req |=> !i_dmem_req)
    else
    begin
        $error("data request longer than one cycle");
        assert_fails++;
    end

    // Write enable only rides on a data request
    we_with_req_a: assert property (@(posedge clk) disable iff (!rst_n)
        i_dmem_we |-> i_dmem_req)
    else
    begin
        $error("data write enable without a data request");
        assert_fails++;
    end

endmodule

bind cpu_top cpu_props props_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_imem_req (o_imem_req),
    .i_dmem_req (o_dmem_req),
    .i_dmem_we  (o_dmem_we)
);

// ==== testbench/cpu_tb.sv ====
// Core testbench with clock, reset, memory models, test table, checker and reporting
`timescale 1ns/1ns
`include "cpu_consts.svh"

module cpu_tb;

    localparam int          REQ_TIMEOUT  = 64;
    localparam int          RESET_CYCLES = 16;
    localparam int          NUM_TESTS    = 10;
    localparam logic [15:0] LOAD_A_ADDR  = 16'h1004;
    localparam logic [15:0] LOAD_B_ADDR  = 16'h0FFE;

    typedef enum logic [1:0] {T_ADD, T_SUB, T_SLT, T_MUL} test_op_e;

    // Next request the program should produce
    typedef enum logic [1:0] {R_FETCH, R_LOAD, R_STORE, R_LAST_FETCH} req_kind_e;

    typedef struct packed {
        test_op_e    op;
        logic [15:0] a;
        logic [15:0] b;
        logic [4:0]  imm;
        logic        tail_jump;
        logic [12:0] tail_field;
        logic [15:0] exp_data;
        logic [15:0] exp_addr;
        logic [15:0] exp_next;
    } test_row_t;

    logic                   clk;
    logic                   rst_n;
    logic                   imem_req;
    logic [`CPU_DATA_W-1:0] imem_addr;
    logic                   imem_valid;
    logic [`CPU_DATA_W-1:0] imem_data;
    logic                   dmem_req;
    logic                   dmem_we;
    logic [`CPU_DATA_W-1:0] dmem_addr;
    logic [`CPU_DATA_W-1:0] dmem_wdata;
    logic                   dmem_valid;
    logic [`CPU_DATA_W-1:0] dmem_rdata;

    logic [15:0] imem [5];
    logic [15:0] dmem [0:65535];
    test_row_t   rows [NUM_TESTS];
    logic [15:0] lfsr_state;
    int          latency_hits [4];
    int          error_count;
    int          fail_tests;
    logic        aborted;

    cpu_top dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .o_imem_req   (imem_req),
        .o_imem_addr  (imem_addr),
        .i_imem_valid (imem_valid),
        .i_imem_data  (imem_data),
        .o_dmem_req   (dmem_req),
        .o_dmem_we    (dmem_we),
        .o_dmem_addr  (dmem_addr),
        .o_dmem_wdata (dmem_wdata),
        .i_dmem_valid (dmem_valid),
        .i_dmem_rdata (dmem_rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ==================================================
    // Helpers
    // ==================================================
    // r3 = r1 op r2
    function automatic logic [15:0] op_word(test_op_e op);
        case (op)
            T_ADD:   return {3'b000, 4'd1, 4'd2, 4'd3, 1'b0};
            T_SUB:   return {3'b000, 4'd1, 4'd2, 4'd3, 1'b1};
            T_SLT:   return {3'b001, 4'd1, 4'd2, 4'd3, 1'b0};
            default: return {3'b001, 4'd1, 4'd2, 4'd3, 1'b1};
        endcase
    endfunction

    function automatic logic [15:0] imem_word(logic [15:0] addr);
        if (addr >= 16'h1000 && addr < 16'h1005)
            return imem[addr - 16'h1000];
        return addr ^ 16'h5A5A;
    endfunction

    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // Two fresh LFSR bits give a delay of 1 to 4 cycles
    task automatic pick_latency(output int latency);
        latency = 1;
        for (int k = 0; k < 2; k++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            latency    = latency + (int'(lfsr_state[0]) << k);
        end
        latency_hits[latency-1]++;
    endtask

    task automatic check_val(string name, logic [15:0] got, logic [15:0] exp);
        if (got !== exp)
        begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic flag_error(string what);
        $display("%s", what);
        error_count++;
        aborted = 1'b1;
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        check_val("o_imem_req", imem_req, 16'h0);
        check_val("o_dmem_req", dmem_req, 16'h0);
        rst_n = 1'b1;
    endtask

    // ==================================================
    // Memory models
    // ==================================================
    task automatic serve(req_kind_e kind, logic [15:0] exp_addr, logic [15:0] exp_wdata);
        int          cycles;
        int          latency;
        logic        want_data;
        logic [15:0] addr;
        if (aborted)
            return;
        want_data = (kind == R_LOAD) || (kind == R_STORE);
        cycles    = 0;
        do
        begin
            @(negedge clk);
            cycles++;
        end
        while (!imem_req && !dmem_req && cycles < REQ_TIMEOUT);
        if (!imem_req && !dmem_req)
        begin
            flag_error("timeout waiting for a memory request");
            return;
        end
        if (want_data != dmem_req)
        begin
            flag_error(want_data ? "fetch request where a data request was due"
                                 : "data request where a fetch was due");
            return;
        end
        if (want_data)
        begin
            addr = dmem_addr;
            check_val("o_dmem_addr", dmem_addr, exp_addr);
            check_val("o_dmem_we", dmem_we, kind == R_STORE);
            if (kind == R_STORE)
                check_val("o_dmem_wdata", dmem_wdata, exp_wdata);
        end
        else
        begin
            addr = imem_addr;
            check_val("o_imem_addr", imem_addr, exp_addr);
        end
        if (kind == R_LAST_FETCH)
            return;
        pick_latency(latency);
        repeat (latency) @(negedge clk);
        if (kind == R_STORE)
            dmem[addr] = dmem_wdata;
        imem_data  = imem_word(addr);
        dmem_rdata = dmem[addr];
        imem_valid = !want_data;
        dmem_valid = want_data;
        @(negedge clk);
        imem_valid = 1'b0;
        dmem_valid = 1'b0;
    endtask

    // ==================================================
    // Test table and sequence
    // ==================================================
    task automatic fill_table();
        // op, a, b, SW imm, tail is J, BEQ imm or J target, store data, store addr, next PC
        rows[0] = {T_ADD, 16'h0005, 16'h0003, 5'h00, 1'b0, 13'h0003, 16'h0008, 16'h100A, 16'h1005};
        rows[1] = {T_SUB, 16'h0003, 16'h0007, 5'h1F, 1'b1, 13'h0123, 16'hFFFC, 16'h1004, 16'h0123};
        rows[2] = {T_SLT, 16'hFFFE, 16'h0001, 5'h04, 1'b0, 13'h0002, 16'h0001, 16'h1004, 16'h1005};
        rows[3] = {T_SLT, 16'h0001, 16'hFFFE, 5'h10, 1'b1, 13'h1FFF, 16'h0000, 16'h0FE2, 16'h1FFF};
        rows[4] = {T_MUL, 16'h0123, 16'h0045, 5'h07, 1'b0, 13'h0005, 16'h4E6F, 16'h1254, 16'h1005};
        rows[5] = {T_MUL, 16'hFFFD, 16'h0500, 5'h00, 1'b0, 13'h001F, 16'hF100, 16'h0FFA, 16'h1005};
        rows[6] = {T_ADD, 16'h7FFF, 16'h7FFF, 5'h01, 1'b0, 13'h0003, 16'hFFFE, 16'h1000, 16'h1008};
        rows[7] = {T_SUB, 16'h1234, 16'h1234, 5'h1C, 1'b0, 13'h001E, 16'h0000, 16'h3460, 16'h1003};
        rows[8] = {T_MUL, 16'h0100, 16'h0100, 5'h03, 1'b0, 13'h0010, 16'h0000, 16'h1206, 16'h0FF5};
        rows[9] = {T_SUB, 16'h8000, 16'h0001, 5'h0F, 1'b1, 13'h0000, 16'h7FFF, 16'h101E, 16'h0000};
    endtask

    task automatic run_test(int idx, test_row_t row);
        int errors_before;
        errors_before = error_count;
        aborted       = 1'b0;
        // LW r1, LW r2, op, SW r3 at imm(r1), then BEQ r1, r2 or J
        imem[0] = {3'b010, 4'd0, 4'd1, 5'h02};
        imem[1] = {3'b010, 4'd0, 4'd2, 5'h1F};
        imem[2] = op_word(row.op);
        imem[3] = {3'b011, 4'd1, 4'd3, row.imm};
        imem[4] = row.tail_jump ? {3'b101, row.tail_field}
                                : {3'b100, 4'd1, 4'd2, row.tail_field[4:0]};
        dmem[LOAD_A_ADDR] = row.a;
        dmem[LOAD_B_ADDR] = row.b;
        apply_reset();
        serve(R_FETCH, 16'h1000, '0);
        serve(R_LOAD, LOAD_A_ADDR, '0);
        serve(R_FETCH, 16'h1001, '0);
        serve(R_LOAD, LOAD_B_ADDR, '0);
        serve(R_FETCH, 16'h1002, '0);
        serve(R_FETCH, 16'h1003, '0);
        serve(R_STORE, row.exp_addr, row.exp_data);
        serve(R_FETCH, 16'h1004, '0);
        serve(R_LAST_FETCH, row.exp_next, '0);
        if (error_count == errors_before)
            $display("test %0d %s: ok", idx, row.op.name());
        else
        begin
            $display("test %0d %s: FAILED", idx, row.op.name());
            fail_tests++;
        end
    endtask

    initial
    begin
        rst_n       = 1'b0;
        imem_valid  = 1'b0;
        imem_data   = '0;
        dmem_valid  = 1'b0;
        dmem_rdata  = '0;
        lfsr_state  = 16'd13;
        error_count = 0;
        fail_tests  = 0;
        aborted     = 1'b0;
        for (int l = 0; l < 4; l++)
            latency_hits[l] = 0;
        for (int addr_i = 0; addr_i < 65536; addr_i++)
            dmem[addr_i] = 16'(addr_i) ^ 16'hC3A5;
        fill_table();
        for (int t = 0; t < NUM_TESTS; t++)
            run_test(t, rows[t]);
        for (int l = 0; l < 4; l++)
        begin
            if (latency_hits[l] == 0)
                flag_error($sformatf("memory latency of %0d cycles never exercised", l + 1));
        end
        if (dut_i.props_i.assert_fails != 0)
            flag_error("request strobe assertions failed");
        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 NUM_TESTS, NUM_TESTS - fail_tests, fail_tests, error_count);
        if (error_count == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// ==== cpu_top.f ====
+incdir+source
source/cpu_pkg.sv
source/cpu_alu.sv
source/cpu_regfile.sv
source/cpu_datapath.sv
source/cpu_control.sv
source/cpu_top.sv
testbench/cpu_props.sv
testbench/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: cpu_top

sources:
  - include_dirs:
      - source
    files:
      - source/cpu_pkg.sv
      - source/cpu_alu.sv
      - source/cpu_regfile.sv
      - source/cpu_datapath.sv
      - source/cpu_control.sv
      - source/cpu_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/cpu_props.sv
      - testbench/cpu_tb.sv
